/* source/apb_pkg.sv */
`default_nettype none

package apb_pkg;

	localparam int addr_width = 12;                  // Byte address width of the APB bus.
	localparam int data_width = 32;                  // Data width of the APB bus.
	localparam int strb_width = data_width / 8;      // One strobe bit per data byte.

	// Signals driven by the requester side of the bus.
	typedef struct packed {
		logic [addr_width-1:0] paddr;                // Byte address of the transfer.
		logic                  psel;                 // Completer select.
		logic                  penable;              // High in the access phase.
		logic                  pwrite;               // High for a write, low for a read.
		logic [data_width-1:0] pwdata;               // Write data.
		logic [strb_width-1:0] pstrb;                // Byte lanes that a write updates.
	} apb_req_t;

	// Signals driven by the completer side of the bus.
	typedef struct packed {
		logic [data_width-1:0] prdata;               // Read data, valid with pready.
		logic                  pready;               // Completer ends the access phase.
		logic                  pslverr;              // Transfer failed, valid with pready.
	} apb_rsp_t;

	// One command from the host.
	typedef struct packed {
		logic [addr_width-1:0] addr;                 // Byte address.
		logic                  write;                // High for a write.
		logic [data_width-1:0] wdata;                // Write data.
		logic [strb_width-1:0] strb;                 // Byte strobes for a write.
	} host_cmd_t;

	// Result of one completed command.
	typedef struct packed {
		logic [data_width-1:0] rdata;                // Read data, zero for writes.
		logic                  err;                  // Error reported by the completer.
	} host_rsp_t;

	// Address map, selected by paddr bits 11 to 8.
	localparam logic [3:0] region_status  = 4'd0;   // Read-only status word.
	localparam logic [3:0] region_control = 4'd1;   // Read/write control words.

endpackage

`default_nettype wire

/* source/apb_requester.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_requester import apb_pkg::*; (
	input  wire logic       pclk,                  // APB clock.
	input  wire logic       rst,                   // Synchronous reset, active high.

	input  wire logic       cmd_valid,             // One-cycle command strobe from the host.
	input  wire host_cmd_t  cmd,                   // Command that goes with cmd_valid.
	output logic            busy,                  // Command in flight, new strobes are ignored.
	output logic            rsp_valid,             // One-cycle pulse when rsp is valid.
	output host_rsp_t       rsp,                   // Registered result of the command.

	output apb_req_t        req,                   // Requester side of the APB bus.
	input  wire apb_rsp_t   bus_rsp                // Completer side of the APB bus.
);

	typedef enum logic [1:0] {
		st_idle,                                 // No transfer on the bus.
		st_setup,                                // psel high, penable low.
		st_access                                // psel and penable high until pready.
	} state_t;

	state_t    state;                            // Transfer phase.
	host_cmd_t cmd_q;                            // Command held stable for the whole transfer.
	logic      take;                             // Command accepted this cycle.
	logic      done;                             // Access phase ends this cycle.

	// Busy stays high through the cycle of rsp_valid, so the host sees it drop only
	// once the result is in hand.
	assign busy = (state != st_idle) || rsp_valid;
	assign take = cmd_valid && !busy;            // Strobes during busy are dropped.
	assign done = (state == st_access) && bus_rsp.pready;

	// Phase sequencing and the response strobe.
	always_ff @(posedge pclk) begin
		if (rst) begin
			state     <= st_idle;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;                   // Pulse lasts a single cycle.
			case (state)
				st_idle: begin
					if (take) begin
						state <= st_setup;       // Setup phase follows in the next cycle.
					end
				end
				st_setup: begin
					state <= st_access;          // Setup always lasts exactly one cycle.
				end
				st_access: begin
					if (bus_rsp.pready) begin
						state     <= st_idle;
						rsp_valid <= 1'b1;       // Result is registered at this same edge.
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// Command capture and response register.
	always_ff @(posedge pclk) begin
		if (take) begin
			cmd_q <= cmd;                        // Held until the next accepted command.
		end
		if (done) begin
			rsp.rdata <= bus_rsp.prdata;         // Sampled only while pready is high.
			rsp.err   <= bus_rsp.pslverr;
		end
	end

	// Bus request: the payload comes from the held command, the phase from the FSM.
	always_comb begin
		req.paddr   = cmd_q.addr;
		req.pwrite  = cmd_q.write;
		req.pwdata  = cmd_q.wdata;
		req.pstrb   = cmd_q.strb;
		req.psel    = (state != st_idle);        // High in both setup and access.
		req.penable = (state == st_access);      // High only in access.
	end

endmodule

`default_nettype wire

/* source/apb_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_decoder import apb_pkg::*; (
	input  wire apb_req_t   req,                   // Request from the requester.

	output apb_req_t        req_status,            // Request copy for the status completer.
	output apb_req_t        req_control,           // Request copy for the control completer.

	input  wire apb_rsp_t   rsp_status,            // Response of the status completer.
	input  wire apb_rsp_t   rsp_control,           // Response of the control completer.

	output apb_rsp_t        rsp                    // Merged response to the requester.
);

	logic [3:0] region;                          // Address region, paddr bits 11 to 8.
	logic       hit_status;                      // Region belongs to the status completer.
	logic       hit_control;                     // Region belongs to the control completer.

	assign region      = req.paddr[addr_width-1 -: 4];
	assign hit_status  = (region == region_status);
	assign hit_control = (region == region_control);

	// Both completers see the full request, but only the selected one gets psel.
	always_comb begin
		req_status       = req;
		req_status.psel  = req.psel && hit_status;
		req_control      = req;
		req_control.psel = req.psel && hit_control;
	end

	// Response merge.
	always_comb begin
		if (hit_status) begin
			rsp = rsp_status;                    // Status region owns the response.
		end else if (hit_control) begin
			rsp = rsp_control;                   // Control region owns the response.
		end else begin
			// Nothing lives here, so the decoder completes the transfer itself
			// without wait states and flags it as failed.
			rsp.prdata  = '0;
			rsp.pready  = req.psel && req.penable;
			rsp.pslverr = req.psel && req.penable;
		end
	end

endmodule

`default_nettype wire

/* source/apb_status_register.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_status_register import apb_pkg::*; (
	input  wire apb_req_t              req,        // Request, psel only when this region is hit.
	output apb_rsp_t                   rsp,        // Response back to the decoder.

	input  wire logic [data_width-1:0] status      // Word returned by every read.
);

	logic access;                                // Access phase of a transfer to this completer.

	assign access = req.psel && req.penable;

	always_comb begin
		rsp.pready  = access;                    // No wait states.
		rsp.prdata  = '0;                        // Zero outside a read access.
		rsp.pslverr = 1'b0;

		if (access) begin
			if (req.pwrite) begin
				rsp.pslverr = 1'b1;              // Register is read-only.
			end else begin
				rsp.prdata = status;             // Offset within the region is ignored.
			end
		end
	end

endmodule

`default_nettype wire

/* source/apb_control_register.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_control_register import apb_pkg::*; #(
	parameter int NUM_REGS = 4                     // Number of control words, 1 to 64.
) (
	input  wire logic             pclk,            // APB clock.
	input  wire logic             rst,             // Synchronous reset, active high.

	input  wire apb_req_t         req,             // Request, psel only when this region is hit.
	output apb_rsp_t              rsp,             // Response back to the decoder.

	output logic [data_width-1:0] ctrl [NUM_REGS]  // Current control words.
);

	// Just wide enough to address NUM_REGS words.
	localparam int idx_width = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

	logic [5:0]           index;                 // Word index, paddr bits 7 to 2.
	logic [idx_width-1:0] word_sel;              // Index trimmed to the array size.
	logic                 in_range;              // Index names an existing word.
	logic                 access;                // Access phase of a transfer to this completer.
	logic                 wr_en;                 // A valid write completes this cycle.

	assign index    = req.paddr[7:2];
	assign word_sel = index[idx_width-1:0];      // Only used when in_range is high.
	assign in_range = (int'(index) < NUM_REGS);
	assign access   = req.psel && req.penable;
	assign wr_en    = access && req.pwrite && in_range;

	// Read path and error flag, both combinational.
	always_comb begin
		rsp.pready  = access;                    // No wait states.
		rsp.pslverr = access && !in_range;       // Missing words fail for reads and writes.
		rsp.prdata  = '0;

		if (access && !req.pwrite && in_range) begin
			rsp.prdata = ctrl[word_sel];
		end
	end

	// Write path. The word changes at the edge that ends the access cycle, and
	// only the lanes with a strobe set are touched.
	always_ff @(posedge pclk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				ctrl[i] <= '0;                   // Every control word starts cleared.
			end
		end else if (wr_en) begin
			for (int b = 0; b < strb_width; b++) begin
				if (req.pstrb[b]) begin
					ctrl[word_sel][8*b +: 8] <= req.pwdata[8*b +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* source/apb_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_subsystem import apb_pkg::*; #(
	parameter int NUM_REGS = 4                     // Number of control words, 1 to 64.
) (
	input  wire logic                  pclk,       // APB clock.
	input  wire logic                  rst,        // Synchronous reset, active high.

	input  wire logic                  cmd_valid,  // One-cycle command strobe.
	input  wire host_cmd_t             cmd,        // Command that goes with cmd_valid.
	output logic                       busy,       // Command in flight.
	output logic                       rsp_valid,  // One-cycle result strobe.
	output host_rsp_t                  rsp,        // Result that goes with rsp_valid.

	input  wire logic [data_width-1:0] status,     // Status word shown in the status region.
	output logic [data_width-1:0]      ctrl [NUM_REGS] // Control words.
);

	apb_req_t req;                               // Requester to decoder.
	apb_rsp_t bus_rsp;                           // Decoder to requester.
	apb_req_t req_status;                        // Decoder to status completer.
	apb_rsp_t rsp_status;                        // Status completer to decoder.
	apb_req_t req_control;                       // Decoder to control completer.
	apb_rsp_t rsp_control;                       // Control completer to decoder.

	apb_requester i_requester (
		.pclk      (pclk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.busy      (busy),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.req       (req),
		.bus_rsp   (bus_rsp)
	);

	apb_decoder i_decoder (
		.req         (req),
		.req_status  (req_status),
		.req_control (req_control),
		.rsp_status  (rsp_status),
		.rsp_control (rsp_control),
		.rsp         (bus_rsp)
	);

	apb_status_register i_status (
		.req    (req_status),
		.rsp    (rsp_status),
		.status (status)
	);

	apb_control_register #(
		.NUM_REGS (NUM_REGS)
	) i_control (
		.pclk (pclk),
		.rst  (rst),
		.req  (req_control),
		.rsp  (rsp_control),
		.ctrl (ctrl)
	);

endmodule

`default_nettype wire

/* testbench/apb_subsystem_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_subsystem_tb import apb_pkg::*; ;

	localparam int NUM_REGS   = 4;                // Control words in the DUT.
	localparam int wait_limit = 50;               // Cycles any single wait may take.

	logic                  pclk = 1'b0;           // Free-running clock.
	logic                  rst;                   // Synchronous reset, active high.
	logic                  cmd_valid;             // Host command strobe.
	host_cmd_t             cmd;                   // Host command.
	logic                  busy;                  // DUT has a command in flight.
	logic                  rsp_valid;             // DUT result strobe.
	host_rsp_t             rsp;                   // DUT result.
	logic [data_width-1:0] status;                // Word the status region shows.
	logic [data_width-1:0] ctrl [NUM_REGS];       // Control words from the DUT.

	logic [data_width-1:0] model [NUM_REGS];      // Expected control words.
	logic [31:0]           lfsr_state;            // Random source state.
	int                    value_errors   = 0;    // Wrong values seen.
	int                    timeout_errors = 0;    // Waits that ran out.

	apb_subsystem #(
		.NUM_REGS (NUM_REGS)
	) i_dut (
		.pclk      (pclk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.busy      (busy),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.status    (status),
		.ctrl      (ctrl)
	);

	always #10 pclk = ~pclk;                      // 20 ns period.

	// One step of a 32-bit Galois LFSR with taps x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// Takes n bits with one LFSR step for each and packs them into the low bits.
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value      = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return value;
	endfunction

	task automatic expect_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			$display("error %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic expect_flag(input string name, input logic exp, input logic act);
		assert (act === exp) else begin
			$display("error %s: expected %b, actual %b", name, exp, act);
			value_errors++;
		end
	endtask

	// Every ctrl word of the DUT must match the model.
	task automatic check_ctrl_words(input string name);
		for (int i = 0; i < NUM_REGS; i++) begin
			expect_value($sformatf("%s ctrl[%0d]", name, i), model[i], ctrl[i]);
		end
	endtask

	// Runs one command from a falling edge and returns at the falling edge of rsp_valid's cycle.
	task automatic issue_command(input string name, input host_cmd_t c,
			output host_rsp_t r, output int latency);
		int waited;
		waited  = 0;
		r       = '0;
		latency = 0;
		while (busy && waited < wait_limit) begin
			@(negedge pclk);
			waited++;
		end
		assert (!busy) else begin
			$display("%s: busy stayed high for %0d cycles, command not sent", name, waited);
			timeout_errors++;
		end
		if (!busy) begin
			cmd       = c;
			cmd_valid = 1'b1;
			@(negedge pclk);                      // Strobe is taken at the rising edge between.
			cmd_valid = 1'b0;
			latency   = 1;
			while (!rsp_valid && latency < wait_limit) begin
				@(negedge pclk);
				latency++;
			end
			assert (rsp_valid) else begin
				$display("%s: no response within %0d cycles", name, latency);
				timeout_errors++;
			end
			r = rsp;                              // Stable for the whole cycle of the pulse.
		end
	endtask

	initial begin
		host_cmd_t c;
		host_rsp_t r;
		int        lat;
		int        idx;
		logic [3:0] region;

		lfsr_state = 32'hec42_da78;
		rst        = 1'b1;
		cmd_valid  = 1'b0;
		cmd        = '0;
		status     = '0;
		for (int i = 0; i < NUM_REGS; i++) begin
			model[i] = '0;                        // Reset value of every control word.
		end
		repeat (3) @(negedge pclk);
		rst = 1'b0;

		// Reset state.
		expect_flag("reset busy", 1'b0, busy);
		expect_flag("reset rsp_valid", 1'b0, rsp_valid);
		check_ctrl_words("reset");

		// Status reads at random offsets with a fresh status word for each.
		for (int n = 0; n < 5; n++) begin
			status  = random_bits(32);
			c       = '0;
			c.addr  = {region_status, 8'(random_bits(8))};
			issue_command("status read", c, r, lat);
			expect_value("status read rdata", status, r.rdata);
			expect_flag("status read err", 1'b0, r.err);
			expect_value("status read latency", 32'd3, 32'(lat));
		end

		// The status region is read-only.
		c       = '0;
		c.addr  = {region_status, 8'(random_bits(8))};
		c.write = 1'b1;
		c.wdata = random_bits(32);
		c.strb  = '1;
		issue_command("status write", c, r, lat);
		expect_flag("status write err", 1'b1, r.err);
		expect_value("status write rdata", 32'd0, r.rdata);

		// Byte-strobed writes to valid words that are each read back.
		for (int n = 0; n < 12; n++) begin
			idx     = int'(random_bits(6) % NUM_REGS);
			c       = '0;
			c.addr  = {region_control, 6'(idx), 2'b00};
			c.write = 1'b1;
			c.wdata = random_bits(32);
			c.strb  = strb_width'(random_bits(strb_width));
			for (int b = 0; b < strb_width; b++) begin
				if (c.strb[b]) begin
					model[idx][8*b +: 8] = c.wdata[8*b +: 8]; // Only strobed lanes change.
				end
			end
			issue_command("control write", c, r, lat);
			expect_flag("control write err", 1'b0, r.err);
			check_ctrl_words("control write");
			c.write = 1'b0;
			issue_command("control read", c, r, lat);
			expect_value("control read rdata", model[idx], r.rdata);
			expect_flag("control read err", 1'b0, r.err);
		end

		// Indexes past the last word fail and leave the words alone.
		for (int n = 0; n < 4; n++) begin
			idx     = NUM_REGS + int'(random_bits(6) % (64 - NUM_REGS));
			c       = '0;
			c.addr  = {region_control, 6'(idx), 2'b00};
			c.write = n[0];                       // Alternate reads and writes.
			c.wdata = random_bits(32);
			c.strb  = '1;
			issue_command("control out of range", c, r, lat);
			expect_flag("control out of range err", 1'b1, r.err);
			check_ctrl_words("control out of range");
		end

		// Unmapped regions are answered by the decoder with an error.
		for (int n = 0; n < 6; n++) begin
			region  = 4'(2 + random_bits(4) % 14);
			c       = '0;
			c.addr  = {region, 8'(random_bits(8))};
			c.write = n[0];
			c.wdata = random_bits(32);
			c.strb  = '1;
			issue_command("unmapped", c, r, lat);
			expect_flag("unmapped err", 1'b1, r.err);
			expect_value("unmapped rdata", 32'd0, r.rdata);
			check_ctrl_words("unmapped");
		end

		$display("errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
source/apb_pkg.sv
source/apb_requester.sv
source/apb_decoder.sv
source/apb_status_register.sv
source/apb_control_register.sv
source/apb_subsystem.sv
testbench/apb_subsystem_tb.sv

/* Makefile */
# Verilator simulation of the APB register subsystem.

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f verilog.f --top-module apb_subsystem_tb \
		-Mdir obj_dir
	./obj_dir/Vapb_subsystem_tb | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
